// File: rtl/rvfi_trace_pkg.sv
/* RVFI tracer package
   Width constants, probe structs, scoreboard entry and trace record */

`default_nettype none

package rvfi_trace_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned VLEN          = 32;     // Virtual address
  localparam int unsigned TRANS_ID_BITS = 3;      // Scoreboard index
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned BE_BITS       = XLEN / 8;

  // Environment call causes, still counted as retired
  localparam logic [XLEN-1:0] CAUSE_ECALL_U = XLEN'(8);
  localparam logic [XLEN-1:0] CAUSE_ECALL_S = XLEN'(9);
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = XLEN'(11);

  typedef logic [1:0] priv_lvl_t;

  // --------------------
  // Pipeline probes
  // --------------------
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic        is_compressed;
    logic        issue_ack;
    logic        flush;
  } fetch_probe_t;

  typedef struct packed {
    logic                     valid;
    logic                     ack;
    logic                     flush_unissued;
    logic [TRANS_ID_BITS-1:0] issue_pointer;
    logic [XLEN-1:0]          rs1_fwd;
    logic [XLEN-1:0]          rs2_fwd;
  } decode_probe_t;

  typedef struct packed {
    logic [VLEN-1:0]          vaddr;
    logic                     is_load;
    logic                     is_store;
    logic [BE_BITS-1:0]       be;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          wdata;       // Store data
  } lsu_probe_t;

  // One commit port
  typedef struct packed {
    logic                     valid;
    logic                     ack;
    logic [TRANS_ID_BITS-1:0] pointer;
    logic [VLEN-1:0]          pc;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [XLEN-1:0]          result;
    logic [XLEN-1:0]          wdata;
  } commit_probe_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] cause;
    priv_lvl_t       priv_lvl;
  } except_probe_t;

  // --------------------
  // Tracer state and output
  // --------------------
  typedef struct packed {
    logic [XLEN-1:0]    rs1_rdata;
    logic [XLEN-1:0]    rs2_rdata;
    logic [VLEN-1:0]    lsu_addr;
    logic [BE_BITS-1:0] lsu_rmask;
    logic [BE_BITS-1:0] lsu_wmask;
    logic [XLEN-1:0]    lsu_wdata;
    logic [31:0]        instr;
  } sb_entry_t;

  typedef struct packed {
    logic                     valid;
    logic [31:0]              insn;
    logic                     trap;
    logic [XLEN-1:0]          cause;
    priv_lvl_t                mode;
    logic [REG_ADDR_BITS-1:0] rs1_addr;
    logic [REG_ADDR_BITS-1:0] rs2_addr;
    logic [REG_ADDR_BITS-1:0] rd_addr;
    logic [XLEN-1:0]          rs1_rdata;
    logic [XLEN-1:0]          rs2_rdata;
    logic [XLEN-1:0]          rd_wdata;
    logic [VLEN-1:0]          pc_rdata;
    logic [VLEN-1:0]          mem_addr;
    logic [BE_BITS-1:0]       mem_rmask;
    logic [BE_BITS-1:0]       mem_wmask;
    logic [XLEN-1:0]          mem_wdata;
    logic [XLEN-1:0]          mem_rdata;
  } rvfi_instr_t;

endpackage

`default_nettype wire

// File: rtl/rvfi_issue_capture.sv
/* Decode-stage instruction capture
   Holds the fetched instruction until decode takes it, compressed words zero-extended */

`timescale 1ns/1ps
`default_nettype none

module rvfi_issue_capture
  import rvfi_trace_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  fetch_probe_t fetch_probe_i,
  output logic [31:0]  issue_instr_o
);

  logic        valid_q, valid_d;
  logic [31:0] instr_q, instr_d;
  logic        load;

  // Holder free or being drained this cycle
  assign load = fetch_probe_i.valid && (!valid_q || fetch_probe_i.issue_ack);

  // Upper half of a 16-bit instruction is meaningless
  assign instr_d = fetch_probe_i.is_compressed ? {16'b0, fetch_probe_i.instr[15:0]}
                                               : fetch_probe_i.instr;

  always_comb begin
    valid_d = valid_q;
    if (fetch_probe_i.issue_ack) valid_d = 1'b0;   // Taken by decode
    if (load)                    valid_d = 1'b1;
    if (fetch_probe_i.flush)     valid_d = 1'b0;   // Flush wins
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_q <= instr_d;
    end
  end

  assign issue_instr_o = instr_q;

  // --------------------
  // Checks
  // --------------------
  // A word with low bits 11 is a full-size encoding, fetch must not flag it compressed
  a_compressed_encoding : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_probe_i.valid && fetch_probe_i.is_compressed |-> fetch_probe_i.instr[1:0] != 2'b11
  );

endmodule

`default_nettype wire

// File: rtl/rvfi_sb_mem.sv
/* Scoreboard side memory for the tracer
   Captures operands and instruction at issue and memory access info from the LSU */

`timescale 1ns/1ps
`default_nettype none

module rvfi_sb_mem
  import rvfi_trace_pkg::*;
#(
  parameter int unsigned NrSbEntries   = 8,
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  decode_probe_t                      decode_probe_i,
  input  logic          [31:0]               issue_instr_i,
  input  lsu_probe_t                         lsu_probe_i,
  input  commit_probe_t [NrCommitPorts-1:0]  commit_probe_i,
  output sb_entry_t     [NrCommitPorts-1:0]  entry_o
);

  sb_entry_t [NrSbEntries-1:0] mem_q, mem_d;

  logic               accept;
  logic [BE_BITS-1:0] lsu_rmask;
  logic [BE_BITS-1:0] lsu_wmask;
  logic               lsu_update;

  // --------------------
  // Write side
  // --------------------
  assign accept = decode_probe_i.valid && decode_probe_i.ack && !decode_probe_i.flush_unissued;

  assign lsu_rmask  = lsu_probe_i.is_load  ? lsu_probe_i.be : '0;
  assign lsu_wmask  = lsu_probe_i.is_store ? lsu_probe_i.be : '0;
  assign lsu_update = (lsu_rmask != '0) || (lsu_wmask != '0);

  always_comb begin
    mem_d = mem_q;

    // New transaction, memory fields start empty
    if (accept) begin
      mem_d[decode_probe_i.issue_pointer] = '{
        rs1_rdata: decode_probe_i.rs1_fwd,
        rs2_rdata: decode_probe_i.rs2_fwd,
        lsu_addr:  '0,
        lsu_rmask: '0,
        lsu_wmask: '0,
        lsu_wdata: '0,
        instr:     issue_instr_i
      };
    end

    // LSU comes second so it overrides a same-cycle issue write
    if (lsu_rmask != '0) begin
      mem_d[lsu_probe_i.trans_id].lsu_addr  = lsu_probe_i.vaddr;
      mem_d[lsu_probe_i.trans_id].lsu_rmask = lsu_rmask;
    end else if (lsu_wmask != '0) begin
      mem_d[lsu_probe_i.trans_id].lsu_addr  = lsu_probe_i.vaddr;
      mem_d[lsu_probe_i.trans_id].lsu_wmask = lsu_wmask;
      mem_d[lsu_probe_i.trans_id].lsu_wdata = lsu_probe_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  // --------------------
  // Read side
  // --------------------
  // One read per commit port at its commit pointer
  always_comb begin
    for (int i = 0; i < NrCommitPorts; i++) begin
      entry_o[i] = mem_q[commit_probe_i[i].pointer];
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_issue_ptr_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    accept |-> decode_probe_i.issue_pointer < NrSbEntries
  );

  a_lsu_id_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    lsu_update |-> lsu_probe_i.trans_id < NrSbEntries
  );

  // LSU handles a single access kind per cycle
  a_lsu_kind_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(lsu_probe_i.is_load && lsu_probe_i.is_store)
  );

endmodule

`default_nettype wire

// File: rtl/rvfi_commit_pack.sv
/* Commit packer for one port
   Builds the RVFI trace record from commit, exception and scoreboard data */

`timescale 1ns/1ps
`default_nettype none

module rvfi_commit_pack
  import rvfi_trace_pkg::*;
(
  input  commit_probe_t commit_probe_i,
  input  except_probe_t except_probe_i,
  input  sb_entry_t     entry_i,
  output rvfi_instr_t   rvfi_o
);

  logic trap;
  logic is_ecall;
  logic retired;

  // --------------------
  // Retirement
  // --------------------
  // Exception hits whatever this port commits
  assign trap = commit_probe_i.valid && except_probe_i.valid;

  assign is_ecall = (except_probe_i.cause == CAUSE_ECALL_U) ||
                    (except_probe_i.cause == CAUSE_ECALL_S) ||
                    (except_probe_i.cause == CAUSE_ECALL_M);

  // An ecall traps yet has done its work
  assign retired = (commit_probe_i.ack && !except_probe_i.valid) || (trap && is_ecall);

  // --------------------
  // Record
  // --------------------
  always_comb begin
    rvfi_o.valid     = retired;
    rvfi_o.insn      = entry_i.instr;
    rvfi_o.trap      = trap;
    rvfi_o.cause     = except_probe_i.cause;
    rvfi_o.mode      = except_probe_i.priv_lvl;

    // Register side
    rvfi_o.rs1_addr  = commit_probe_i.rs1;
    rvfi_o.rs2_addr  = commit_probe_i.rs2;
    rvfi_o.rd_addr   = commit_probe_i.rd;
    rvfi_o.rs1_rdata = entry_i.rs1_rdata;   // Operands as seen at issue
    rvfi_o.rs2_rdata = entry_i.rs2_rdata;
    rvfi_o.rd_wdata  = commit_probe_i.wdata;
    rvfi_o.pc_rdata  = commit_probe_i.pc;

    // Memory side
    rvfi_o.mem_addr  = entry_i.lsu_addr;
    rvfi_o.mem_rmask = entry_i.lsu_rmask;
    rvfi_o.mem_wmask = entry_i.lsu_wmask;
    rvfi_o.mem_wdata = entry_i.lsu_wdata;
    rvfi_o.mem_rdata = commit_probe_i.result;   // Load data is the FU result
  end

endmodule

`default_nettype wire

// File: rtl/rvfi_tracer.sv
/* RVFI instruction tracer top level
   Passive observer turning pipeline probes into one trace record per commit port */

`timescale 1ns/1ps
`default_nettype none

module rvfi_tracer
  import rvfi_trace_pkg::*;
#(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned NrSbEntries   = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  fetch_probe_t                      fetch_probe_i,
  input  decode_probe_t                     decode_probe_i,
  input  lsu_probe_t                        lsu_probe_i,
  input  except_probe_t                     except_probe_i,
  input  commit_probe_t [NrCommitPorts-1:0] commit_probe_i,
  output rvfi_instr_t   [NrCommitPorts-1:0] rvfi_o
);

  logic      [31:0]              issue_instr;   // Word waiting for decode
  sb_entry_t [NrCommitPorts-1:0] sb_entry;

  // --------------------
  // Decode stage
  // --------------------
  rvfi_issue_capture u_issue_capture (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_probe_i (fetch_probe_i),
    .issue_instr_o (issue_instr)
  );

  // --------------------
  // Issue stage
  // --------------------
  rvfi_sb_mem #(
    .NrSbEntries   (NrSbEntries),
    .NrCommitPorts (NrCommitPorts)
  ) u_sb_mem (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .decode_probe_i (decode_probe_i),
    .issue_instr_i  (issue_instr),
    .lsu_probe_i    (lsu_probe_i),
    .commit_probe_i (commit_probe_i),
    .entry_o        (sb_entry)
  );

  // --------------------
  // Commit stage
  // --------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : g_port
    rvfi_commit_pack u_commit_pack (
      .commit_probe_i (commit_probe_i[i]),
      .except_probe_i (except_probe_i),
      .entry_i        (sb_entry[i]),
      .rvfi_o         (rvfi_o[i])
    );
  end

endmodule

`default_nettype wire

// File: include/rvfi_tracer_table.svh
/* Stimulus and expected-value table for the tracer testbench
   One row per transaction, applied in order */

`ifndef RVFI_TRACER_TABLE_SVH
`define RVFI_TRACER_TABLE_SVH

localparam logic [1:0] LSU_NONE  = 2'd0;
localparam logic [1:0] LSU_LOAD  = 2'd1;
localparam logic [1:0] LSU_STORE = 2'd2;

typedef struct packed {
  logic        port;        // Commit port
  logic [2:0]  idx;         // Scoreboard index
  logic [31:0] instr;
  logic        cmp;         // Compressed flag
  logic        fflush;      // Fetch flush before the real fetch
  logic        dflush;      // Flush-unissued at decode
  logic [1:0]  lsu_kind;
  logic [31:0] addr;
  logic [3:0]  be;
  logic [31:0] sdata;
  logic        exc;
  logic [31:0] cause;
  logic        exp_valid;
  logic        exp_trap;
  logic [31:0] exp_insn;
  logic [3:0]  exp_rmask;
  logic [3:0]  exp_wmask;
} row_t;

localparam int NUM_ROWS = 11;

// port, idx, instr, cmp, fflush, dflush, lsu, addr, be, sdata,
//   exc, cause, valid, trap, insn, rmask, wmask
localparam row_t ROWS [NUM_ROWS] = '{
  '{1'b0, 3'd1, 32'h00A3_0333, 1'b0, 1'b0, 1'b0, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b0, 32'd0, 1'b1, 1'b0, 32'h00A3_0333, 4'h0, 4'h0},
  '{1'b0, 3'd2, 32'hDEAD_4505, 1'b1, 1'b0, 1'b0, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b0, 32'd0, 1'b1, 1'b0, 32'h0000_4505, 4'h0, 4'h0},
  '{1'b0, 3'd3, 32'h0042_A303, 1'b0, 1'b0, 1'b0, LSU_LOAD, 32'h8000_1000, 4'hF, 32'h0,
    1'b0, 32'd0, 1'b1, 1'b0, 32'h0042_A303, 4'hF, 4'h0},
  '{1'b0, 3'd4, 32'h0062_A223, 1'b0, 1'b0, 1'b0, LSU_STORE, 32'h8000_2004, 4'h3,
    32'h1234_ABCD, 1'b0, 32'd0, 1'b1, 1'b0, 32'h0062_A223, 4'h0, 4'h3},
  '{1'b0, 3'd5, 32'h0000_0073, 1'b0, 1'b0, 1'b0, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b1, 32'd11, 1'b1, 1'b1, 32'h0000_0073, 4'h0, 4'h0},
  '{1'b0, 3'd6, 32'h0000_0000, 1'b0, 1'b0, 1'b0, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b1, 32'd2, 1'b0, 1'b1, 32'h0000_0000, 4'h0, 4'h0},
  '{1'b1, 3'd7, 32'h0015_0513, 1'b0, 1'b0, 1'b0, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b0, 32'd0, 1'b1, 1'b0, 32'h0015_0513, 4'h0, 4'h0},
  '{1'b1, 3'd1, 32'h1234_5678, 1'b0, 1'b0, 1'b1, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b0, 32'd0, 1'b1, 1'b0, 32'h00A3_0333, 4'h0, 4'h0},
  '{1'b1, 3'd0, 32'h40B5_0533, 1'b0, 1'b1, 1'b0, LSU_NONE, 32'h0, 4'h0, 32'h0,
    1'b0, 32'd0, 1'b1, 1'b0, 32'h40B5_0533, 4'h0, 4'h0},
  '{1'b0, 3'd2, 32'h00B1_0023, 1'b0, 1'b0, 1'b0, LSU_STORE, 32'h8000_3001, 4'h1,
    32'h0000_00AB, 1'b1, 32'd8, 1'b1, 1'b1, 32'h00B1_0023, 4'h0, 4'h1},
  '{1'b1, 3'd3, 32'h0022_9303, 1'b0, 1'b0, 1'b0, LSU_LOAD, 32'h8000_4002, 4'h3, 32'h0,
    1'b1, 32'd5, 1'b0, 1'b1, 32'h0022_9303, 4'h3, 4'h0}
};

`endif

// File: verification/tb_rvfi_tracer.sv
/* Testbench for the RVFI tracer
   Applies the transaction table and checks the trace records */

`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_tracer
  import rvfi_trace_pkg::*;
();

  `include "rvfi_tracer_table.svh"

  localparam int POLL_LIMIT = 100;   // ns without a rising edge

  logic                clk_i;
  logic                rst_ni;
  fetch_probe_t        fetch_probe;
  decode_probe_t       decode_probe;
  lsu_probe_t          lsu_probe;
  except_probe_t       except_probe;
  commit_probe_t [1:0] commit_probe;
  rvfi_instr_t   [1:0] rvfi;

  int          err_cnt;
  logic        timed_out;
  logic [31:0] m_rs1   [8];   // Expected scoreboard contents
  logic [31:0] m_rs2   [8];
  logic [31:0] m_addr  [8];
  logic [31:0] m_wdata [8];

  rvfi_tracer dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_probe_i  (fetch_probe),
    .decode_probe_i (decode_probe),
    .lsu_probe_i    (lsu_probe),
    .except_probe_i (except_probe),
    .commit_probe_i (commit_probe),
    .rvfi_o         (rvfi)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------
  // Polls off the edge grid and returns 2 ns after the next rising edge
  task automatic next_cycle();
    int polls;
    polls = 0;
    if (!timed_out) begin
      #0.5;
      while (clk_i !== 1'b0 && polls < POLL_LIMIT) begin
        #1;
        polls++;
      end
      while (clk_i !== 1'b1 && polls < POLL_LIMIT) begin
        #1;
        polls++;
      end
      if (polls >= POLL_LIMIT) begin
        timed_out = 1'b1;
        $display("Timeout: no rising clock edge seen");
      end else begin
        #1.5;
      end
    end
  endtask

  task automatic drive_idle();
    fetch_probe  = '0;
    decode_probe = '0;
    lsu_probe    = '0;
    except_probe = '{valid: 1'b0, cause: '0, priv_lvl: 2'b11};
    commit_probe = '0;
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      err_cnt++;
      $display("ERR %0t: %s is %08h, expected %08h", $time, name, got, want);
    end
  endtask

  task automatic apply_row(input int r);
    row_t        rw;
    int          p;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] result;
    logic [31:0] wdata;
    priv_lvl_t   priv;
    rw       = ROWS[r];
    p        = int'(rw.port);
    rs1_data = $urandom;
    rs2_data = $urandom;
    result   = $urandom;
    wdata    = $urandom;
    priv     = (r % 2 == 0) ? 2'b11 : 2'b00;   // Alternate M and U mode

    // Fetch with an optional flushed junk word first
    if (rw.fflush) begin
      fetch_probe = '{valid: 1'b1, instr: rw.instr ^ 32'hFFFF_0000, is_compressed: 1'b0,
                      issue_ack: 1'b0, flush: 1'b1};
      next_cycle();
    end
    fetch_probe = '{valid: 1'b1, instr: rw.instr, is_compressed: rw.cmp,
                    issue_ack: 1'b0, flush: 1'b0};
    next_cycle();

    // Decode accept
    fetch_probe  = '{valid: 1'b0, instr: '0, is_compressed: 1'b0, issue_ack: 1'b1, flush: 1'b0};
    decode_probe = '{valid: 1'b1, ack: 1'b1, flush_unissued: rw.dflush,
                     issue_pointer: rw.idx, rs1_fwd: rs1_data, rs2_fwd: rs2_data};
    next_cycle();
    if (!rw.dflush) begin
      m_rs1[rw.idx]   = rs1_data;
      m_rs2[rw.idx]   = rs2_data;
      m_addr[rw.idx]  = '0;
      m_wdata[rw.idx] = '0;
    end

    // LSU update
    fetch_probe  = '0;
    decode_probe = '0;
    lsu_probe    = '{vaddr: rw.addr, is_load: rw.lsu_kind == LSU_LOAD,
                     is_store: rw.lsu_kind == LSU_STORE, be: rw.be,
                     trans_id: rw.idx, wdata: rw.sdata};
    next_cycle();
    if (rw.lsu_kind != LSU_NONE && rw.be != 4'h0) begin
      m_addr[rw.idx] = rw.addr;
      if (rw.lsu_kind == LSU_STORE) m_wdata[rw.idx] = rw.sdata;
    end

    // Commit and check the combinational record
    lsu_probe       = '0;
    commit_probe[p] = '{valid: 1'b1, ack: 1'b1, pointer: rw.idx, pc: 32'h1000 + 32'(r * 4),
                        rs1: 5'(r + 1), rs2: 5'(r + 2), rd: 5'(r + 3),
                        result: result, wdata: wdata};
    except_probe    = '{valid: rw.exc, cause: rw.cause, priv_lvl: priv};
    #10;
    check_field("valid", 32'(rvfi[p].valid), 32'(rw.exp_valid));
    check_field("trap", 32'(rvfi[p].trap), 32'(rw.exp_trap));
    check_field("cause", rvfi[p].cause, rw.cause);
    check_field("mode", 32'(rvfi[p].mode), 32'(priv));
    check_field("insn", rvfi[p].insn, rw.exp_insn);
    check_field("pc_rdata", rvfi[p].pc_rdata, 32'h1000 + 32'(r * 4));
    check_field("rs1_addr", 32'(rvfi[p].rs1_addr), 32'((r + 1) % 32));
    check_field("rs2_addr", 32'(rvfi[p].rs2_addr), 32'((r + 2) % 32));
    check_field("rd_addr", 32'(rvfi[p].rd_addr), 32'((r + 3) % 32));
    check_field("rs1_rdata", rvfi[p].rs1_rdata, m_rs1[rw.idx]);
    check_field("rs2_rdata", rvfi[p].rs2_rdata, m_rs2[rw.idx]);
    check_field("rd_wdata", rvfi[p].rd_wdata, wdata);
    check_field("mem_addr", rvfi[p].mem_addr, m_addr[rw.idx]);
    check_field("mem_rmask", 32'(rvfi[p].mem_rmask), 32'(rw.exp_rmask));
    check_field("mem_wmask", 32'(rvfi[p].mem_wmask), 32'(rw.exp_wmask));
    check_field("mem_wdata", rvfi[p].mem_wdata, m_wdata[rw.idx]);
    check_field("mem_rdata", rvfi[p].mem_rdata, result);
    check_field("idle port valid", 32'(rvfi[1 - p].valid), 32'd0);
    next_cycle();
    drive_idle();
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(81));
    rst_ni    = 1'b0;
    err_cnt   = 0;
    timed_out = 1'b0;
    drive_idle();
    for (int i = 0; i < 8; i++) begin
      m_rs1[i]   = '0;
      m_rs2[i]   = '0;
      m_addr[i]  = '0;
      m_wdata[i] = '0;
    end

    repeat (4) next_cycle();
    rst_ni = 1'b1;
    #10;
    check_field("port 0 valid after reset", 32'(rvfi[0].valid), 32'd0);
    check_field("port 1 valid after reset", 32'(rvfi[1].valid), 32'd0);
    next_cycle();

    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      apply_row(r);
    end
    next_cycle();

    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/rvfi_trace_pkg.sv
rtl/rvfi_issue_capture.sv
rtl/rvfi_sb_mem.sv
rtl/rvfi_commit_pack.sv
rtl/rvfi_tracer.sv
verification/tb_rvfi_tracer.sv

// File: run_sim.sh
#!/bin/sh
# Build the tracer testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rvfi_tracer -f tb.f -o sim_tb \
  > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
  && { echo "Failure reported in sim.log"; exit 1; } \
  || grep -q "Simulation finished: PASS" sim.log \
  || { echo "No result line in sim.log"; exit 1; }

exit 0
